// ==== hdl/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of the rename subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RN_NUM_REGS   32      // Architectural registers
`define RN_TAG_BITS   6       // Physical tag width, 64 tags
`define RN_ROB_DEPTH  8       // Reorder buffer entries, also the credit pool
`define RN_NUM_LANES  2       // Execution lanes sharing the writeback bus

`endif

// ==== hdl/rename_pkg.sv ====
`include "rename_cfg.svh"

package rename_pkg;

    typedef logic [$clog2(`RN_NUM_REGS)-1:0] archReg_t;
    typedef logic [`RN_TAG_BITS-1:0] physTag_t;
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0] robIdx_t;
    typedef logic [$clog2(`RN_ROB_DEPTH):0] credit_t;   // Holds 0 up to the full depth

    // Decoded op as it arrives from the front end
    typedef struct packed {
        archReg_t dst;
        archReg_t src1;
        archReg_t src2;
    } decOp_t;

    typedef struct packed {
        archReg_t dst;
        physTag_t dstTag;
        physTag_t src1Tag;
        physTag_t src2Tag;
        logic     src1Ready;
        logic     src2Ready;
        robIdx_t  robIdx;
        physTag_t prevTag;     // Speculative tag that this op replaces
    } renamedOp_t;

    typedef struct packed {
        logic     valid;
        physTag_t tag;
        robIdx_t  robIdx;
    } wbReq_t;

    typedef struct packed {
        logic     valid;
        archReg_t dst;
        physTag_t tag;
        physTag_t prevTag;
    } commit_t;

endpackage

// ==== hdl/renameTable.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module renameTable (
    input  logic                             clk,
    input  logic                             rst,
    input  rename_pkg::archReg_t [1:0]       lookupIds,
    input  logic                             renWe,
    input  rename_pkg::archReg_t             renDst,
    input  rename_pkg::physTag_t             renTag,
    input  rename_pkg::wbReq_t               wbBus,
    input  rename_pkg::commit_t              commit,
    input  logic                             mispredict,
    output rename_pkg::physTag_t [1:0]       lookupTags,
    output logic [1:0]                       lookupReady,
    output rename_pkg::physTag_t             prevTag
);
    import rename_pkg::*;

    physTag_t specTag [`RN_NUM_REGS];
    physTag_t comTag  [`RN_NUM_REGS];
    logic     avail   [`RN_NUM_REGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup with writeback forwarding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookupTags[i]  = specTag[lookupIds[i]];
            lookupReady[i] = avail[lookupIds[i]];
            // A result on the bus this cycle counts as ready already
            if (wbBus.valid && wbBus.tag == specTag[lookupIds[i]])
                lookupReady[i] = 1'b1;
        end
    end

    assign prevTag = specTag[renDst];   // Mapping about to be replaced by the rename

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Map updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_NUM_REGS; i++) begin
                specTag[i] <= physTag_t'(i);   // Identity mapping out of reset
                comTag[i]  <= physTag_t'(i);
                avail[i]   <= 1'b1;
            end
        end else begin
            // The bus carries only a tag, so every live mapping is compared
            if (wbBus.valid) begin
                for (int i = 1; i < `RN_NUM_REGS; i++) begin
                    if (specTag[i] == wbBus.tag)
                        avail[i] <= 1'b1;
                end
            end

            if (mispredict) begin
                // Everything committed has its value, so all of it is ready
                for (int i = 1; i < `RN_NUM_REGS; i++) begin
                    specTag[i] <= comTag[i];
                    avail[i]   <= 1'b1;
                end
            end else if (renWe && renDst != '0) begin
                specTag[renDst] <= renTag;
                avail[renDst]   <= 1'b0;   // Overrides a writeback to the old tag
            end

            if (commit.valid && commit.dst != '0)
                comTag[commit.dst] <= commit.tag;
        end
    end

endmodule

// ==== hdl/tagFreeList.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module tagFreeList (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 allocate,
    input  rename_pkg::commit_t  commit,
    input  logic                 mispredict,
    output rename_pkg::physTag_t freeTag,
    output logic                 freeValid
);
    import rename_pkg::*;

    localparam int numTags = 1 << `RN_TAG_BITS;

    // The architectural registers own the low tags out of reset
    localparam logic [numTags-1:0] resetUsed =
        {{(numTags - `RN_NUM_REGS){1'b0}}, {`RN_NUM_REGS{1'b1}}};

    logic [numTags-1:0] specUsed;
    logic [numTags-1:0] comUsed;

    // Lowest free tag wins, so scan from the top and let lower hits overwrite
    always_comb begin
        freeTag   = '0;
        freeValid = 1'b0;
        for (int t = numTags - 1; t >= 0; t--) begin
            if (!specUsed[t]) begin
                freeTag   = physTag_t'(t);
                freeValid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            specUsed <= resetUsed;
            comUsed  <= resetUsed;
        end else begin
            if (mispredict) begin
                specUsed <= comUsed;   // Drops every tag taken since the last commit
            end else if (allocate) begin
                specUsed[freeTag] <= 1'b1;
            end

            if (commit.valid && commit.dst != '0) begin
                comUsed[commit.tag]      <= 1'b1;
                comUsed[commit.prevTag]  <= 1'b0;
                specUsed[commit.prevTag] <= 1'b0;   // Never equal to freeTag, no clash
            end
        end
    end

endmodule

// ==== hdl/reorderBuffer.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module reorderBuffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  rename_pkg::archReg_t allocDst,
    input  rename_pkg::physTag_t allocTag,
    input  rename_pkg::physTag_t allocPrev,
    input  rename_pkg::wbReq_t   wbBus,
    input  logic                 mispredict,
    output rename_pkg::robIdx_t  allocIdx,
    output rename_pkg::commit_t  commit,
    output logic                 creditReturn
);
    import rename_pkg::*;

    robIdx_t head;
    robIdx_t tail;

    logic [`RN_ROB_DEPTH-1:0] entryValid;
    logic [`RN_ROB_DEPTH-1:0] entryDone;

    // Payload of each entry
    archReg_t entryDst  [`RN_ROB_DEPTH];
    physTag_t entryTag  [`RN_ROB_DEPTH];
    physTag_t entryPrev [`RN_ROB_DEPTH];

    assign allocIdx = tail;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // In-order retirement from the head
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        commit.valid   = entryValid[head] && entryDone[head] && !mispredict;
        commit.dst     = entryDst[head];
        commit.tag     = entryTag[head];
        commit.prevTag = entryPrev[head];
    end

    assign creditReturn = commit.valid;   // One credit back per retired entry

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            head       <= '0;
            tail       <= '0;
            entryValid <= '0;
            entryDone  <= '0;
        end else begin
            // Credits upstream keep this from overrunning the head
            if (alloc) begin
                entryValid[tail] <= 1'b1;
                entryDone[tail]  <= 1'b0;
                tail             <= tail + 1'b1;
            end

            if (wbBus.valid && entryValid[wbBus.robIdx])
                entryDone[wbBus.robIdx] <= 1'b1;

            if (commit.valid) begin
                entryValid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entryDst[tail]  <= allocDst;
            entryTag[tail]  <= allocTag;
            entryPrev[tail] <= allocPrev;
        end
    end

endmodule

// ==== hdl/wbArbiter.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module wbArbiter (
    input  logic                                     clk,
    input  logic                                     rst,
    input  rename_pkg::wbReq_t [`RN_NUM_LANES-1:0]   laneReq,
    output logic [`RN_NUM_LANES-1:0]                 laneGrant,
    output rename_pkg::wbReq_t                       wbBus
);
    import rename_pkg::*;

    logic lastWin;   // Lane that got the bus most recently

    always_comb begin
        laneGrant = '0;
        if (laneReq[0].valid && laneReq[1].valid) begin
            // Conflict goes to the lane that lost last time
            if (lastWin)
                laneGrant[0] = 1'b1;
            else
                laneGrant[1] = 1'b1;
        end else begin
            laneGrant[0] = laneReq[0].valid;
            laneGrant[1] = laneReq[1].valid;
        end
    end

    always_comb begin
        wbBus = '0;
        if (laneGrant[0])
            wbBus = laneReq[0];
        else if (laneGrant[1])
            wbBus = laneReq[1];
    end

    always_ff @(posedge clk) begin
        if (rst)
            lastWin <= 1'b1;   // Makes lane 0 the first to win a conflict
        else if (|laneGrant)
            lastWin <= laneGrant[1];
    end

endmodule

// ==== hdl/renameStage.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module renameStage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           inValid,
    input  rename_pkg::decOp_t             inOp,
    input  rename_pkg::physTag_t           freeTag,
    input  logic                           freeValid,
    input  rename_pkg::physTag_t [1:0]     lookupTags,
    input  logic [1:0]                     lookupReady,
    input  rename_pkg::physTag_t           prevTag,
    input  rename_pkg::robIdx_t            allocIdx,
    input  logic                           creditReturn,
    input  logic                           mispredict,
    output logic                           inReady,
    output logic                           accept,
    output logic                           outValid,
    output rename_pkg::renamedOp_t         outOp
);
    import rename_pkg::*;

    localparam credit_t fullCredits = credit_t'(`RN_ROB_DEPTH);

    credit_t credits;   // Free reorder buffer entries as seen from rename
    logic    live;      // Low for the first cycle out of reset

    assign inReady = live && credits != '0 && freeValid && !mispredict;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            live     <= 1'b0;
            credits  <= fullCredits;
            outValid <= 1'b0;
        end else begin
            live     <= 1'b1;
            outValid <= accept;
            if (mispredict)
                credits <= fullCredits;   // The buffer is empty after the flush
            else
                credits <= credits + credit_t'(creditReturn) - credit_t'(accept);
        end
    end

    // Renamed op register, loaded only on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            outOp.dst       <= inOp.dst;
            outOp.dstTag    <= (inOp.dst != '0) ? freeTag : '0;   // r0 keeps tag 0
            outOp.src1Tag   <= lookupTags[0];
            outOp.src2Tag   <= lookupTags[1];
            outOp.src1Ready <= lookupReady[0];
            outOp.src2Ready <= lookupReady[1];
            outOp.robIdx    <= allocIdx;
            outOp.prevTag   <= prevTag;
        end
    end

endmodule

// ==== hdl/renameUnit.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module renameUnit (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     inValid,
    input  rename_pkg::decOp_t                       inOp,
    input  rename_pkg::wbReq_t [`RN_NUM_LANES-1:0]   laneReq,
    input  logic                                     mispredict,
    output logic                                     inReady,
    output logic                                     outValid,
    output rename_pkg::renamedOp_t                   outOp,
    output logic [`RN_NUM_LANES-1:0]                 laneGrant,
    output rename_pkg::commit_t                      commit
);
    import rename_pkg::*;

    wbReq_t         wbBus;
    logic           accept;
    physTag_t       freeTag;
    logic           freeValid;
    physTag_t [1:0] lookupTags;
    logic [1:0]     lookupReady;
    physTag_t       prevTag;
    robIdx_t        allocIdx;
    logic           creditReturn;

    renameTable table0 (
        .clk(clk), .rst(rst),
        .lookupIds({inOp.src2, inOp.src1}),   // Index 0 is src1
        .renWe(accept), .renDst(inOp.dst), .renTag(freeTag),
        .wbBus(wbBus), .commit(commit), .mispredict(mispredict),
        .lookupTags(lookupTags), .lookupReady(lookupReady), .prevTag(prevTag)
    );

    // An op writing r0 takes no tag from the free list
    tagFreeList freeList0 (
        .clk(clk), .rst(rst), .allocate(accept && inOp.dst != '0),
        .commit(commit), .mispredict(mispredict),
        .freeTag(freeTag), .freeValid(freeValid)
    );

    reorderBuffer rob0 (
        .clk(clk), .rst(rst), .alloc(accept),
        .allocDst(inOp.dst), .allocTag(inOp.dst != '0 ? freeTag : '0), .allocPrev(prevTag),
        .wbBus(wbBus), .mispredict(mispredict),
        .allocIdx(allocIdx), .commit(commit), .creditReturn(creditReturn)
    );

    wbArbiter arb0 (
        .clk(clk), .rst(rst), .laneReq(laneReq), .laneGrant(laneGrant), .wbBus(wbBus)
    );

    renameStage stage0 (
        .clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp),
        .freeTag(freeTag), .freeValid(freeValid),
        .lookupTags(lookupTags), .lookupReady(lookupReady), .prevTag(prevTag),
        .allocIdx(allocIdx), .creditReturn(creditReturn), .mispredict(mispredict),
        .inReady(inReady), .accept(accept), .outValid(outValid), .outOp(outOp)
    );

endmodule

// ==== test/renameUnit_asserts.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module renameUnit_asserts (
    input  logic                                     clk,
    input  logic                                     rst,
    input  rename_pkg::credit_t                      credits,
    input  rename_pkg::wbReq_t [`RN_NUM_LANES-1:0]   laneReq,
    input  logic [`RN_NUM_LANES-1:0]                 laneGrant,
    input  rename_pkg::commit_t                      commit,
    input  logic                                     mispredict
);
    import rename_pkg::*;

    // Credits come back only for entries that were spent
    creditBound: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_t'(`RN_ROB_DEPTH))
        else $error("credit count above the buffer depth");

    grantOneHot: assert property (@(posedge clk) disable iff (rst)
        !(laneGrant[0] && laneGrant[1]))
        else $error("both lanes granted the writeback bus");

    grantHasReq: assert property (@(posedge clk) disable iff (rst)
        (laneGrant & {laneReq[1].valid, laneReq[0].valid}) == laneGrant)
        else $error("grant given to a lane without a request");

    // The flush empties the buffer so nothing is left to retire right after it
    noCommitAfterFlush: assert property (@(posedge clk) disable iff (rst)
        mispredict |=> !commit.valid)
        else $error("commit in the cycle after a mispredict");

endmodule

bind renameUnit renameUnit_asserts asserts0 (
    .clk(clk), .rst(rst), .credits(stage0.credits),
    .laneReq(arb0.laneReq), .laneGrant(arb0.laneGrant),
    .commit(rob0.commit), .mispredict(rob0.mispredict)
);

// ==== test/renameUnit_tb.sv ====
`timescale 1ns/1ns
`include "rename_cfg.svh"

module renameUnit_tb;
    import rename_pkg::*;

    localparam int numRows = 16;
    localparam int numTags = 1 << `RN_TAG_BITS;

    typedef struct packed {
        decOp_t     op;
        logic       lane;
        logic [3:0] delay;              // Cycles to writeback, 0 draws a random delay
        logic       mispredictAfter;
    } stimRow_t;

    typedef struct packed {
        int     due;
        logic   lane;
        wbReq_t req;
    } pendWb_t;

    logic                     clk;
    logic                     rst;
    logic                     inValid;
    decOp_t                   inOp;
    wbReq_t [`RN_NUM_LANES-1:0] laneReq;
    logic                     mispredict;
    logic                     inReady;
    logic                     outValid;
    renamedOp_t               outOp;
    logic [`RN_NUM_LANES-1:0] laneGrant;
    commit_t                  commit;

    stimRow_t stim [numRows];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    physTag_t                 specMap [`RN_NUM_REGS];
    physTag_t                 comMap  [`RN_NUM_REGS];
    logic                     avail   [`RN_NUM_REGS];
    logic [numTags-1:0]       specUsed;
    logic [numTags-1:0]       comUsed;
    logic [`RN_ROB_DEPTH-1:0] doneVec;
    renamedOp_t               robQ [$];       // In-flight ops, oldest first
    pendWb_t                  pending [$];    // Writebacks not yet put on a lane
    wbReq_t                   held [`RN_NUM_LANES];
    robIdx_t                  robTail;
    int                       credits;
    logic                     live;
    logic                     favorLane0;
    logic                     flushNext;
    logic [`RN_NUM_LANES-1:0] wonLast;
    renamedOp_t               expOut;
    logic                     expOutValid;
    int                       expRow;
    int                       row;
    int                       cycle;
    int                       checks;
    int                       errors;

    renameUnit dut0 (
        .clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp), .laneReq(laneReq),
        .mispredict(mispredict), .inReady(inReady), .outValid(outValid), .outOp(outOp),
        .laneGrant(laneGrant), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((numRows * 40 + 4) * 20);
        $display("Watchdog expired before all ops retired");
        $display("TEST FAIL");
        $finish;
    end

    function automatic stimRow_t makeRow(int dst, int s1, int s2, int lane, int dly, int fl);
        stimRow_t r;
        r.op.dst          = archReg_t'(dst);
        r.op.src1         = archReg_t'(s1);
        r.op.src2         = archReg_t'(s2);
        r.lane            = lane[0];
        r.delay           = dly[3:0];
        r.mispredictAfter = fl[0];
        return r;
    endfunction

    task checkFlag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task checkRenamed(input renamedOp_t expected, input renamedOp_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: renamed op %h, expected %h", $time, actual, expected);
        end
    endtask

    task checkCommit(input commit_t expected, input commit_t actual);
        checks++;
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            errors++;
            $display("** Error at %0t ns: commit %h, expected %h", $time, actual, expected);
        end
    endtask

    task checkGrant(input logic [`RN_NUM_LANES-1:0] expected,
                    input logic [`RN_NUM_LANES-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: grant %b, expected %b", $time, actual, expected);
        end
    endtask

    task resetModel;
        specUsed = '0;
        for (int i = 0; i < `RN_NUM_REGS; i++) begin
            specMap[i]  = physTag_t'(i);
            comMap[i]   = physTag_t'(i);
            avail[i]    = 1'b1;
            specUsed[i] = 1'b1;
        end
        comUsed    = specUsed;
        doneVec    = '0;
        robTail    = '0;
        credits    = `RN_ROB_DEPTH;
        live       = 1'b0;              // No accepts in the first cycle out of reset
        favorLane0 = 1'b1;
    endtask

    // Sampled at the falling edge, where every DUT output has settled
    task sampleCycle;
        renamedOp_t               exp;
        commit_t                  expCommit;
        wbReq_t                   bus;
        logic [`RN_NUM_LANES-1:0] expGrant;
        logic                     expReady;
        logic                     freeOk;
        physTag_t                 freeT;
        int                       d;
        if (expOutValid) begin
            checkRenamed(expOut, outOp);
            $display("test %0d: r%0d renamed to tag %0d, %0d errors so far",
                     expRow, expOut.dst, expOut.dstTag, errors);
        end
        checkFlag("outValid", expOutValid, outValid);

        if (laneReq[0].valid && laneReq[1].valid)
            expGrant = favorLane0 ? 2'b01 : 2'b10;
        else
            expGrant = {laneReq[1].valid, laneReq[0].valid};
        checkGrant(expGrant, laneGrant);
        wonLast = laneGrant;
        bus = '0;
        if (expGrant[0])
            bus = laneReq[0];
        else if (expGrant[1])
            bus = laneReq[1];
        if (expGrant != '0)
            favorLane0 = expGrant[1];

        expCommit = '0;
        if (robQ.size() != 0 && !mispredict && doneVec[robQ[0].robIdx])
            expCommit = '{valid: 1'b1, dst: robQ[0].dst, tag: robQ[0].dstTag,
                          prevTag: robQ[0].prevTag};
        checkCommit(expCommit, commit);

        freeOk = 1'b0;
        freeT  = '0;
        for (int t = 0; t < numTags; t++) begin
            if (!freeOk && !specUsed[t]) begin
                freeT  = physTag_t'(t);
                freeOk = 1'b1;
            end
        end
        expReady = live && credits != 0 && freeOk && !mispredict;
        checkFlag("inReady", expReady, inReady);

        exp = '0;
        if (inValid && expReady) begin
            exp.dst       = inOp.dst;
            exp.dstTag    = (inOp.dst != '0) ? freeT : '0;
            exp.src1Tag   = specMap[inOp.src1];
            exp.src2Tag   = specMap[inOp.src2];
            exp.src1Ready = avail[inOp.src1] || (bus.valid && bus.tag == specMap[inOp.src1]);
            exp.src2Ready = avail[inOp.src2] || (bus.valid && bus.tag == specMap[inOp.src2]);
            exp.robIdx    = robTail;
            exp.prevTag   = specMap[inOp.dst];
        end

        if (bus.valid) begin
            for (int i = 1; i < `RN_NUM_REGS; i++)
                if (specMap[i] == bus.tag)
                    avail[i] = 1'b1;
            foreach (robQ[k])
                if (robQ[k].robIdx == bus.robIdx)
                    doneVec[bus.robIdx] = 1'b1;
        end
        if (expCommit.valid) begin
            if (expCommit.dst != '0) begin
                comMap[expCommit.dst]     = expCommit.tag;
                comUsed[expCommit.tag]    = 1'b1;
                comUsed[expCommit.prevTag]  = 1'b0;
                specUsed[expCommit.prevTag] = 1'b0;
            end
            void'(robQ.pop_front());
            credits++;
        end
        if (mispredict) begin
            for (int i = 1; i < `RN_NUM_REGS; i++) begin
                specMap[i] = comMap[i];
                avail[i]   = 1'b1;
            end
            specUsed = comUsed;
            robQ.delete();
            doneVec = '0;
            robTail = '0;
            credits = `RN_ROB_DEPTH;
        end else if (inValid && expReady) begin
            if (inOp.dst != '0) begin
                specMap[inOp.dst] = freeT;
                avail[inOp.dst]   = 1'b0;
                specUsed[freeT]   = 1'b1;
            end
            doneVec[robTail] = 1'b0;
            robQ.push_back(exp);
            robTail++;
            credits--;
            d = (stim[row].delay == 0) ? 1 + int'($urandom % 4) : int'(stim[row].delay);
            pending.push_back('{due: cycle + d, lane: stim[row].lane,
                                req: '{valid: 1'b1, tag: exp.dstTag, robIdx: exp.robIdx}});
            flushNext = stim[row].mispredictAfter;
            expRow    = row;
            row++;
        end
        expOutValid = inValid && expReady;
        expOut      = exp;
        live        = 1'b1;
    endtask

    task driveCycle;
        logic found;
        cycle++;
        mispredict = flushNext;
        if (flushNext) begin
            pending.delete();               // Lanes drop the work of flushed ops
            held[0] = '0;
            held[1] = '0;
            wonLast = '0;
        end
        flushNext = 1'b0;
        inValid = row < numRows && !mispredict;
        inOp    = (row < numRows) ? stim[row].op : '0;
        for (int l = 0; l < `RN_NUM_LANES; l++) begin
            if (wonLast[l])
                held[l] = '0;
            if (!held[l].valid) begin
                found = 1'b0;
                for (int j = 0; j < pending.size(); j++) begin
                    if (!found && pending[j].lane == l[0] && pending[j].due <= cycle) begin
                        held[l] = pending[j].req;
                        pending.delete(j);
                        found = 1'b1;
                    end
                end
            end
            laneReq[l] = held[l];           // A request stays put until it is granted
        end
    endtask

    initial begin
        void'($urandom(32'he7ca_27bd));
        rst        = 1'b1;
        inValid    = 1'b0;
        inOp       = '0;
        laneReq    = '0;
        mispredict = 1'b0;
        // Columns are dst, src1, src2, lane, writeback delay, mispredict after
        stim[0]  = makeRow(5, 1, 2, 0, 1, 0);
        stim[1]  = makeRow(6, 5, 0, 1, 6, 0);
        stim[2]  = makeRow(7, 6, 5, 0, 2, 0);
        stim[3]  = makeRow(5, 7, 1, 1, 1, 0);
        stim[4]  = makeRow(8, 3, 4, 0, 15, 0);   // Holds the head so the credits run out
        stim[5]  = makeRow(9, 8, 5, 1, 0, 0);
        stim[6]  = makeRow(10, 9, 9, 0, 0, 0);
        stim[7]  = makeRow(11, 10, 8, 1, 0, 0);
        stim[8]  = makeRow(12, 11, 5, 0, 0, 0);
        stim[9]  = makeRow(13, 12, 0, 1, 0, 0);
        stim[10] = makeRow(14, 13, 6, 0, 0, 0);
        stim[11] = makeRow(15, 14, 7, 1, 0, 0);
        stim[12] = makeRow(16, 15, 8, 0, 3, 1);
        stim[13] = makeRow(17, 16, 8, 1, 2, 0);
        stim[14] = makeRow(0, 5, 17, 0, 1, 0);
        stim[15] = makeRow(8, 8, 3, 1, 0, 0);
        held[0]     = '0;
        held[1]     = '0;
        wonLast     = '0;
        flushNext   = 1'b0;
        expOutValid = 1'b0;
        expOut      = '0;
        expRow      = 0;
        row         = 0;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        resetModel();
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        while (row < numRows || robQ.size() != 0 || expOutValid) begin
            @(negedge clk);
            sampleCycle();
            @(posedge clk);
            #2;
            driveCycle();
        end
        $display("%0d tests, %0d checks, %0d errors", numRows, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/renameTable.sv
hdl/tagFreeList.sv
hdl/reorderBuffer.sv
hdl/wbArbiter.sv
hdl/renameStage.sv
hdl/renameUnit.sv
test/renameUnit_asserts.sv
test/renameUnit_tb.sv

// ==== Makefile ====
# Verilator build and run of the rename subsystem testbench

VERILATOR ?= verilator
TOP       ?= renameUnit_tb
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' list.f) hdl/rename_cfg.svh
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f list.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
